//--- hw/rv64_isa_pkg.sv
package rv64_isa_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;
  typedef logic [2:0]  imm_fmt_t;

  // major opcodes in bits [6:0]
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_IMM_32 = 7'b0011011;
  localparam opcode_t LOAD      = 7'b0000011;
  localparam opcode_t STORE     = 7'b0100011;
  localparam opcode_t LUI       = 7'b0110111;
  localparam opcode_t AUIPC     = 7'b0010111;
  localparam opcode_t OP        = 7'b0110011;
  localparam opcode_t OP_32     = 7'b0111011;
  localparam opcode_t JAL       = 7'b1101111;
  localparam opcode_t JALR      = 7'b1100111;
  localparam opcode_t BRANCH    = 7'b1100011;

  localparam funct7_t F7_BASE = 7'b0000000;
  localparam funct7_t F7_ALT  = 7'b0100000;

  // integer ops
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // conditional branches
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  localparam imm_fmt_t IMM_NONE = 3'd0;
  localparam imm_fmt_t IMM_I    = 3'd1;
  localparam imm_fmt_t IMM_U    = 3'd2;
  localparam imm_fmt_t IMM_J    = 3'd3;
  localparam imm_fmt_t IMM_B    = 3'd4;
  localparam imm_fmt_t IMM_S    = 3'd5;

endpackage

//--- hw/exec_ctrl_pkg.sv
package exec_ctrl_pkg;

  typedef logic [7:0] alu_op_t;
  typedef logic [2:0] alu_sel_t;
  typedef logic [7:0] mem_mask_t;
  typedef logic [1:0] fwd_sel_t;
  typedef logic [1:0] redir_kind_t;

  localparam alu_op_t ALU_NONE = 8'd0;
  localparam alu_op_t ALU_OR   = 8'd1;
  localparam alu_op_t ALU_XOR  = 8'd2;
  localparam alu_op_t ALU_AND  = 8'd3;
  localparam alu_op_t ALU_SLL  = 8'd4;
  localparam alu_op_t ALU_SRL  = 8'd5;
  localparam alu_op_t ALU_ADD  = 8'd6;
  localparam alu_op_t ALU_SUB  = 8'd7;
  localparam alu_op_t ALU_SRA  = 8'd8;
  localparam alu_op_t ALU_SLT  = 8'd9;
  localparam alu_op_t ALU_SLTU = 8'd10;
  localparam alu_op_t ALU_SRLW = 8'd11;
  localparam alu_op_t ALU_SUBW = 8'd12;
  localparam alu_op_t ALU_ADDW = 8'd13;
  localparam alu_op_t ALU_SLLW = 8'd14;
  localparam alu_op_t ALU_SRAW = 8'd15;

  // result class seen by the execute stage
  localparam alu_sel_t SEL_NONE    = 3'd0;
  localparam alu_sel_t SEL_LOGIC   = 3'd1;
  localparam alu_sel_t SEL_SHIFT   = 3'd2;
  localparam alu_sel_t SEL_COMPARE = 3'd3;
  localparam alu_sel_t SEL_ARITH   = 3'd4;

  localparam mem_mask_t MASK_BYTE   = 8'h01;
  localparam mem_mask_t MASK_HALF   = 8'h03;
  localparam mem_mask_t MASK_WORD   = 8'h0f;
  localparam mem_mask_t MASK_DOUBLE = 8'hff;

  localparam fwd_sel_t FWD_REGFILE = 2'd0;
  localparam fwd_sel_t FWD_EX      = 2'd1;
  localparam fwd_sel_t FWD_WB      = 2'd2;
  localparam fwd_sel_t FWD_MEM     = 2'd3;

  localparam redir_kind_t REDIR_NONE   = 2'd0;
  localparam redir_kind_t REDIR_SEQ    = 2'd1;
  localparam redir_kind_t REDIR_JALR   = 2'd2;
  localparam redir_kind_t REDIR_TARGET = 2'd3;

endpackage

//--- hw/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder
  import rv64_isa_pkg::*;
  import exec_ctrl_pkg::*;
(
  input  inst_t     inst_i,
  output reg_addr_t rs1_addr_o,
  output reg_addr_t rs2_addr_o,
  output reg_addr_t wb_addr_o,
  output logic      rs1_en_o,
  output logic      rs2_en_o,
  output logic      wb_en_o,
  output logic      rs1_is_pc_o,
  output logic      rs2_is_imm_o,
  output logic      link_o,
  output logic      is_jalr_o,
  output funct3_t   br_funct3_o,
  output logic      is_branch_o,
  output alu_op_t   alu_op_o,
  output alu_sel_t  alu_sel_o,
  output logic      mem_r_en_o,
  output logic      mem_w_en_o,
  output logic      mem_signed_o,
  output mem_mask_t mem_mask_o,
  output imm_fmt_t  imm_fmt_o
);
  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;
  logic    load, i_cls, u_cls, r_cls, b_cls, s_cls, jal, jalr;
  logic    r_sub;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];

  assign load  = (opcode == LOAD);
  assign i_cls = (opcode == OP_IMM) || (opcode == OP_IMM_32) || load;
  assign u_cls = (opcode == LUI) || (opcode == AUIPC);
  assign r_cls = (opcode == OP) || (opcode == OP_32);
  assign b_cls = (opcode == BRANCH);
  assign s_cls = (opcode == STORE);
  assign jal   = (opcode == JAL);
  assign jalr  = (opcode == JALR);
  // only register ops pick sub from funct7
  assign r_sub = r_cls && (funct7 == F7_ALT);

  assign wb_en_o  = i_cls || u_cls || r_cls || jal || jalr;
  assign rs1_en_o = i_cls || r_cls || b_cls || s_cls || jalr;
  assign rs2_en_o = r_cls || b_cls || s_cls;

  // unused fields read as x0
  assign wb_addr_o  = wb_en_o ? inst_i[11:7] : '0;
  assign rs1_addr_o = rs1_en_o ? inst_i[19:15] : '0;
  assign rs2_addr_o = rs2_en_o ? inst_i[24:20] : '0;

  assign rs1_is_pc_o  = jal || jalr || (opcode == AUIPC);
  assign rs2_is_imm_o = i_cls || u_cls || s_cls;
  assign link_o       = jal || jalr;
  assign is_jalr_o    = jalr;
  assign is_branch_o  = b_cls;
  assign br_funct3_o  = funct3;

  always_comb begin
    if (i_cls || jalr) imm_fmt_o = IMM_I;
    else if (u_cls) imm_fmt_o = IMM_U;
    else if (jal) imm_fmt_o = IMM_J;
    else if (b_cls) imm_fmt_o = IMM_B;
    else if (s_cls) imm_fmt_o = IMM_S;
    else imm_fmt_o = IMM_NONE;
  end

  always_comb begin
    alu_op_o = ALU_NONE;
    case (opcode)
      OP_IMM, OP: begin
        case (funct3)
          F3_ADD_SUB: alu_op_o = r_sub ? ALU_SUB : ALU_ADD;
          F3_SLL:     alu_op_o = ALU_SLL;
          F3_SLT:     alu_op_o = ALU_SLT;
          F3_SLTU:    alu_op_o = ALU_SLTU;
          F3_XOR:     alu_op_o = ALU_XOR;
          F3_SRL_SRA: alu_op_o = inst_i[30] ? ALU_SRA : ALU_SRL;
          F3_OR:      alu_op_o = ALU_OR;
          F3_AND:     alu_op_o = ALU_AND;
        endcase
      end
      OP_IMM_32, OP_32: begin
        case (funct3)
          F3_ADD_SUB: alu_op_o = r_sub ? ALU_SUBW : ALU_ADDW;
          F3_SLL:     alu_op_o = ALU_SLLW;
          F3_SRL_SRA: alu_op_o = inst_i[30] ? ALU_SRAW : ALU_SRLW;
          default:    alu_op_o = ALU_NONE;
        endcase
      end
      LUI:                           alu_op_o = ALU_OR;
      LOAD, STORE, AUIPC, JAL, JALR: alu_op_o = ALU_ADD;
      default:                       alu_op_o = ALU_NONE;
    endcase
    // M extension and other funct7 values are not decoded
    if (r_cls && (funct7 != F7_BASE) && (funct7 != F7_ALT)) alu_op_o = ALU_NONE;
  end

  always_comb begin
    case (alu_op_o)
      ALU_OR, ALU_XOR, ALU_AND:                          alu_sel_o = SEL_LOGIC;
      ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLW, ALU_SRLW, ALU_SRAW: alu_sel_o = SEL_SHIFT;
      ALU_SLT, ALU_SLTU:                                 alu_sel_o = SEL_COMPARE;
      ALU_ADD, ALU_SUB, ALU_ADDW, ALU_SUBW:              alu_sel_o = SEL_ARITH;
      default:                                           alu_sel_o = SEL_NONE;
    endcase
  end

  assign mem_r_en_o   = load;
  assign mem_w_en_o   = s_cls;
  // lbu, lhu and lwu have funct3[2] set
  assign mem_signed_o = !(load && funct3[2]);

  always_comb begin
    mem_mask_o = '0;
    if (load || s_cls) begin
      case (funct3[1:0])
        2'b00: mem_mask_o = MASK_BYTE;
        2'b01: mem_mask_o = MASK_HALF;
        2'b10: mem_mask_o = MASK_WORD;
        2'b11: mem_mask_o = MASK_DOUBLE;
      endcase
    end
  end

endmodule

//--- hw/imm_gen.sv
`timescale 1ns/100ps

module imm_gen
  import rv64_isa_pkg::*;
(
  input  inst_t    inst_i,
  input  imm_fmt_t imm_fmt_i,
  output xlen_t    imm_o,
  output xlen_t    b_imm_o,
  output xlen_t    i_imm_o
);
  xlen_t i_imm, u_imm, j_imm, b_imm, s_imm;

  assign i_imm = {{52{inst_i[31]}}, inst_i[31:20]};
  assign u_imm = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
  assign j_imm = {{44{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
  assign b_imm = {{52{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign s_imm = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};

  always_comb begin
    case (imm_fmt_i)
      IMM_I:   imm_o = i_imm;
      IMM_U:   imm_o = u_imm;
      IMM_J:   imm_o = j_imm;
      IMM_B:   imm_o = b_imm;
      IMM_S:   imm_o = s_imm;
      default: imm_o = '0;
    endcase
  end

  // raw copies for the branch unit
  assign i_imm_o = i_imm;
  assign b_imm_o = b_imm;

endmodule

//--- hw/operand_forward.sv
`timescale 1ns/100ps

module operand_forward
  import rv64_isa_pkg::*;
  import exec_ctrl_pkg::*;
(
  input  xlen_t    regfile_data_i,
  input  xlen_t    ex_data_i,
  input  xlen_t    mem_data_i,
  input  xlen_t    wb_data_i,
  input  xlen_t    load_data_i,
  input  fwd_sel_t fwd_sel_i,
  input  logic     load_fwd_i,
  output xlen_t    operand_o
);

  // load data has priority over the select
  always_comb begin
    if (load_fwd_i) begin
      operand_o = load_data_i;
    end else begin
      case (fwd_sel_i)
        FWD_MEM:     operand_o = mem_data_i;
        FWD_EX:      operand_o = ex_data_i;
        FWD_WB:      operand_o = wb_data_i;
        FWD_REGFILE: operand_o = regfile_data_i;
      endcase
    end
  end

endmodule

//--- hw/branch_resolve.sv
`timescale 1ns/100ps

module branch_resolve
  import rv64_isa_pkg::*;
  import exec_ctrl_pkg::*;
(
  input  xlen_t   pc_i,
  input  xlen_t   rs1_val_i,
  input  xlen_t   rs2_val_i,
  input  xlen_t   i_imm_i,
  input  xlen_t   b_imm_i,
  input  funct3_t br_funct3_i,
  input  logic    is_branch_i,
  input  logic    is_jalr_i,
  input  logic    predict_taken_i,
  output logic    redirect_o,
  output xlen_t   redirect_pc_o
);
  logic        taken;
  redir_kind_t kind;

  always_comb begin
    taken = 1'b0;
    if (is_branch_i) begin
      case (br_funct3_i)
        F3_BEQ:  taken = (rs1_val_i == rs2_val_i);
        F3_BNE:  taken = (rs1_val_i != rs2_val_i);
        F3_BLT:  taken = ($signed(rs1_val_i) < $signed(rs2_val_i));
        F3_BGE:  taken = ($signed(rs1_val_i) >= $signed(rs2_val_i));
        F3_BLTU: taken = (rs1_val_i < rs2_val_i);
        F3_BGEU: taken = (rs1_val_i >= rs2_val_i);
        default: taken = 1'b0;
      endcase
    end
  end

  // non-branches resolve as not taken, so a taken prediction on them falls through
  always_comb begin
    if (is_jalr_i) kind = REDIR_JALR;
    else if (predict_taken_i && !taken) kind = REDIR_SEQ;
    else if (!predict_taken_i && taken) kind = REDIR_TARGET;
    else kind = REDIR_NONE;
  end

  assign redirect_o = (kind != REDIR_NONE);

  always_comb begin
    case (kind)
      REDIR_SEQ:    redirect_pc_o = pc_i + 64'd4;
      REDIR_JALR:   redirect_pc_o = (rs1_val_i + i_imm_i) & ~64'd1;
      REDIR_TARGET: redirect_pc_o = pc_i + b_imm_i;
      REDIR_NONE:   redirect_pc_o = '0;
    endcase
  end

endmodule

//--- hw/ex_operand_latch.sv
`timescale 1ns/100ps

module ex_operand_latch
  import rv64_isa_pkg::*;
  import exec_ctrl_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  xlen_t     pc_i,
  input  xlen_t     rs1_val_i,
  input  xlen_t     rs2_val_i,
  input  xlen_t     imm_i,
  input  logic      rs1_en_i,
  input  logic      rs2_en_i,
  input  logic      rs1_is_pc_i,
  input  logic      rs2_is_imm_i,
  input  logic      link_i,
  input  alu_op_t   alu_op_i,
  input  alu_sel_t  alu_sel_i,
  input  reg_addr_t wb_addr_i,
  input  logic      wb_en_i,
  input  logic      mem_r_en_i,
  input  logic      mem_w_en_i,
  input  mem_mask_t mem_mask_i,
  input  logic      mem_signed_i,
  output alu_op_t   ex_alu_op_o,
  output alu_sel_t  ex_alu_sel_o,
  output xlen_t     ex_rs1_data_o,
  output xlen_t     ex_rs2_data_o,
  output xlen_t     ex_pc_o,
  output reg_addr_t ex_wb_addr_o,
  output logic      ex_wb_en_o,
  output logic      ex_mem_r_en_o,
  output logic      ex_mem_w_en_o,
  output mem_mask_t ex_mem_mask_o,
  output logic      ex_mem_signed_o,
  output xlen_t     ex_store_data_o
);
  xlen_t op1, op2, store_data;

  // jalr reads rs1 for its target but links pc+4
  always_comb begin
    if (rs1_en_i && !link_i) op1 = rs1_val_i;
    else if (rs1_is_pc_i) op1 = pc_i;
    else op1 = '0;
  end

  always_comb begin
    if (rs2_is_imm_i) op2 = imm_i;
    else if (rs2_en_i) op2 = rs2_val_i;
    else if (link_i) op2 = 64'd4;
    else op2 = '0;
  end

  always_comb begin
    store_data = '0;
    if (mem_w_en_i) begin
      case (mem_mask_i)
        MASK_BYTE:   store_data = {56'b0, rs2_val_i[7:0]};
        MASK_HALF:   store_data = {48'b0, rs2_val_i[15:0]};
        MASK_WORD:   store_data = {32'b0, rs2_val_i[31:0]};
        MASK_DOUBLE: store_data = rs2_val_i;
        default:     store_data = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_alu_op_o     <= ALU_NONE;
      ex_alu_sel_o    <= SEL_NONE;
      ex_rs1_data_o   <= '0;
      ex_rs2_data_o   <= '0;
      ex_pc_o         <= '0;
      ex_wb_addr_o    <= '0;
      ex_wb_en_o      <= 1'b0;
      ex_mem_r_en_o   <= 1'b0;
      ex_mem_w_en_o   <= 1'b0;
      ex_mem_mask_o   <= '0;
      ex_mem_signed_o <= 1'b0;
      ex_store_data_o <= '0;
    end else begin
      ex_alu_op_o     <= alu_op_i;
      ex_alu_sel_o    <= alu_sel_i;
      ex_rs1_data_o   <= op1;
      ex_rs2_data_o   <= op2;
      ex_pc_o         <= pc_i;
      ex_wb_addr_o    <= wb_addr_i;
      ex_wb_en_o      <= wb_en_i;
      ex_mem_r_en_o   <= mem_r_en_i;
      ex_mem_w_en_o   <= mem_w_en_i;
      ex_mem_mask_o   <= mem_mask_i;
      ex_mem_signed_o <= mem_signed_i;
      ex_store_data_o <= store_data;
    end
  end

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/100ps

module decode_stage
  import rv64_isa_pkg::*;
  import exec_ctrl_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  xlen_t     pc_i,
  input  inst_t     inst_i,
  input  logic      predict_taken_i,
  input  xlen_t     rs1_data_i,
  input  xlen_t     rs2_data_i,
  input  xlen_t     ex_data_i,
  input  xlen_t     mem_data_i,
  input  xlen_t     wb_data_i,
  input  xlen_t     load_data_i,
  input  fwd_sel_t  rs1_fwd_sel_i,
  input  fwd_sel_t  rs2_fwd_sel_i,
  input  logic      rs1_load_fwd_i,
  input  logic      rs2_load_fwd_i,
  output reg_addr_t rs1_addr_o,
  output reg_addr_t rs2_addr_o,
  output logic      rs1_r_en_o,
  output logic      rs2_r_en_o,
  output logic      redirect_o,
  output xlen_t     redirect_pc_o,
  output alu_op_t   ex_alu_op_o,
  output alu_sel_t  ex_alu_sel_o,
  output xlen_t     ex_rs1_data_o,
  output xlen_t     ex_rs2_data_o,
  output xlen_t     ex_pc_o,
  output reg_addr_t ex_wb_addr_o,
  output logic      ex_wb_en_o,
  output logic      ex_mem_r_en_o,
  output logic      ex_mem_w_en_o,
  output mem_mask_t ex_mem_mask_o,
  output logic      ex_mem_signed_o,
  output xlen_t     ex_store_data_o
);
  reg_addr_t wb_addr;
  funct3_t   br_funct3;
  alu_op_t   alu_op;
  alu_sel_t  alu_sel;
  mem_mask_t mem_mask;
  imm_fmt_t  imm_fmt;
  xlen_t     imm, i_imm, b_imm, rs1_val, rs2_val;
  logic      wb_en, rs1_is_pc, rs2_is_imm, link, is_jalr, is_branch;
  logic      mem_r_en, mem_w_en, mem_signed;

  inst_decoder i_inst_decoder (
    .inst_i,
    .rs1_addr_o,      .rs2_addr_o,         .wb_addr_o   (wb_addr),
    .rs1_en_o    (rs1_r_en_o), .rs2_en_o   (rs2_r_en_o), .wb_en_o (wb_en),
    .rs1_is_pc_o (rs1_is_pc),  .rs2_is_imm_o (rs2_is_imm), .link_o (link),
    .is_jalr_o   (is_jalr),    .br_funct3_o (br_funct3),  .is_branch_o (is_branch),
    .alu_op_o    (alu_op),     .alu_sel_o   (alu_sel),
    .mem_r_en_o  (mem_r_en),   .mem_w_en_o  (mem_w_en),   .mem_signed_o (mem_signed),
    .mem_mask_o  (mem_mask),   .imm_fmt_o   (imm_fmt)
  );

  imm_gen i_imm_gen (
    .inst_i,
    .imm_fmt_i (imm_fmt),
    .imm_o     (imm),
    .b_imm_o   (b_imm),
    .i_imm_o   (i_imm)
  );

  operand_forward i_rs1_forward (
    .regfile_data_i (rs1_data_i),
    .ex_data_i, .mem_data_i, .wb_data_i, .load_data_i,
    .fwd_sel_i      (rs1_fwd_sel_i),
    .load_fwd_i     (rs1_load_fwd_i),
    .operand_o      (rs1_val)
  );

  operand_forward i_rs2_forward (
    .regfile_data_i (rs2_data_i),
    .ex_data_i, .mem_data_i, .wb_data_i, .load_data_i,
    .fwd_sel_i      (rs2_fwd_sel_i),
    .load_fwd_i     (rs2_load_fwd_i),
    .operand_o      (rs2_val)
  );

  branch_resolve i_branch_resolve (
    .pc_i,
    .rs1_val_i   (rs1_val),   .rs2_val_i   (rs2_val),
    .i_imm_i     (i_imm),     .b_imm_i     (b_imm),
    .br_funct3_i (br_funct3), .is_branch_i (is_branch), .is_jalr_i (is_jalr),
    .predict_taken_i,
    .redirect_o,
    .redirect_pc_o
  );

  ex_operand_latch i_ex_operand_latch (
    .clk_i, .reset_i, .pc_i,
    .rs1_val_i    (rs1_val),    .rs2_val_i    (rs2_val),    .imm_i  (imm),
    .rs1_en_i     (rs1_r_en_o), .rs2_en_i     (rs2_r_en_o),
    .rs1_is_pc_i  (rs1_is_pc),  .rs2_is_imm_i (rs2_is_imm), .link_i (link),
    .alu_op_i     (alu_op),     .alu_sel_i    (alu_sel),
    .wb_addr_i    (wb_addr),    .wb_en_i      (wb_en),
    .mem_r_en_i   (mem_r_en),   .mem_w_en_i   (mem_w_en),
    .mem_mask_i   (mem_mask),   .mem_signed_i (mem_signed),
    .ex_alu_op_o, .ex_alu_sel_o, .ex_rs1_data_o, .ex_rs2_data_o, .ex_pc_o,
    .ex_wb_addr_o, .ex_wb_en_o, .ex_mem_r_en_o, .ex_mem_w_en_o,
    .ex_mem_mask_o, .ex_mem_signed_o, .ex_store_data_o
  );

endmodule

//--- tb/tb_decode_stage.sv
`timescale 1ns/100ps

module tb_decode_stage;

  localparam int CLK_HALF     = 20;
  localparam int NUM_VEC      = 27;
  localparam int WORDS        = 15;
  localparam int RESET_LIMIT  = 10;
  localparam int SETTLE_LIMIT = 4;

  // word offsets within one vector line
  localparam int F_PC   = 0;
  localparam int F_INST = 1;
  localparam int F_CTL  = 2;
  localparam int F_RS1  = 3;
  localparam int F_RS2  = 4;
  localparam int F_EX   = 5;
  localparam int F_MEM  = 6;
  localparam int F_WB   = 7;
  localparam int F_LD   = 8;
  localparam int F_COMB = 9;
  localparam int F_RPC  = 10;
  localparam int F_REG  = 11;
  localparam int F_OP1  = 12;
  localparam int F_OP2  = 13;
  localparam int F_ST   = 14;

  logic        clk_i;
  logic        reset_i;
  logic [63:0] pc_i, rs1_data_i, rs2_data_i, ex_data_i, mem_data_i, wb_data_i, load_data_i;
  logic [31:0] inst_i;
  logic        predict_taken_i, rs1_load_fwd_i, rs2_load_fwd_i;
  logic [1:0]  rs1_fwd_sel_i, rs2_fwd_sel_i;
  logic [4:0]  rs1_addr_o, rs2_addr_o, ex_wb_addr_o;
  logic        rs1_r_en_o, rs2_r_en_o, redirect_o;
  logic [63:0] redirect_pc_o, ex_rs1_data_o, ex_rs2_data_o, ex_pc_o, ex_store_data_o;
  logic [7:0]  ex_alu_op_o, ex_mem_mask_o;
  logic [2:0]  ex_alu_sel_o;
  logic        ex_wb_en_o, ex_mem_r_en_o, ex_mem_w_en_o, ex_mem_signed_o;

  logic [63:0] stim [0:NUM_VEC*WORDS-1];
  int unsigned cycle = 0;

  decode_stage i_decode_stage (.*);

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  // reset held for four rising edges
  initial begin
    reset_i <= 1'b1;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
  end

  always @(posedge clk_i) cycle <= cycle + 1;

  task automatic fail_run();
    $display("Regression failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    assert (actual === expected) else begin
      $display("Mismatch at time %0d ns: %s expected %h, got %h",
               $time, name, expected, actual);
      fail_run();
    end
  endtask

  function automatic logic [63:0] field(input int v, input int f);
    return stim[v*WORDS+f];
  endfunction

  task automatic drive_nop();
    inst_i          <= 32'h0000_0013;
    pc_i            <= '0;
    predict_taken_i <= 1'b0;
    rs1_data_i      <= '0;
    rs2_data_i      <= '0;
    ex_data_i       <= '0;
    mem_data_i      <= '0;
    wb_data_i       <= '0;
    load_data_i     <= '0;
    rs1_fwd_sel_i   <= 2'd0;
    rs2_fwd_sel_i   <= 2'd0;
    rs1_load_fwd_i  <= 1'b0;
    rs2_load_fwd_i  <= 1'b0;
  endtask

  task automatic apply_vector(input int v);
    logic [63:0] ctl;
    logic [63:0] w;
    ctl = field(v, F_CTL);
    w   = field(v, F_INST);
    pc_i            <= field(v, F_PC);
    inst_i          <= w[31:0];
    predict_taken_i <= ctl[16];
    rs1_fwd_sel_i   <= ctl[13:12];
    rs1_load_fwd_i  <= ctl[8];
    rs2_fwd_sel_i   <= ctl[5:4];
    rs2_load_fwd_i  <= ctl[0];
    rs1_data_i      <= field(v, F_RS1);
    rs2_data_i      <= field(v, F_RS2);
    ex_data_i       <= field(v, F_EX);
    mem_data_i      <= field(v, F_MEM);
    wb_data_i       <= field(v, F_WB);
    load_data_i     <= field(v, F_LD);
  endtask

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (reset_i && waited < RESET_LIMIT);
    if (reset_i) begin
      $display("Timeout: reset was never released");
      fail_run();
    end
  endtask

  // falling edge of the cycle that started when the inputs were applied
  task automatic wait_settle(input int unsigned target, input string what);
    int waited;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (cycle != target && waited < SETTLE_LIMIT);
    if (cycle != target) begin
      $display("Timeout: clock cycle for %s never came", what);
      fail_run();
    end
  endtask

  task automatic check_comb(input int v);
    logic [63:0] c;
    c = field(v, F_COMB);
    check_value("rs1_addr_o", 64'(rs1_addr_o), 64'(c[27:20]));
    check_value("rs2_addr_o", 64'(rs2_addr_o), 64'(c[19:12]));
    check_value("rs1_r_en_o", 64'(rs1_r_en_o), 64'(c[8]));
    check_value("rs2_r_en_o", 64'(rs2_r_en_o), 64'(c[4]));
    check_value("redirect_o", 64'(redirect_o), 64'(c[0]));
    check_value("redirect_pc_o", redirect_pc_o, field(v, F_RPC));
  endtask

  task automatic check_reg(input int v);
    logic [63:0] r;
    r = field(v, F_REG);
    check_value("ex_alu_op_o", 64'(ex_alu_op_o), 64'(r[43:36]));
    check_value("ex_alu_sel_o", 64'(ex_alu_sel_o), 64'(r[35:32]));
    check_value("ex_wb_addr_o", 64'(ex_wb_addr_o), 64'(r[31:24]));
    check_value("ex_wb_en_o", 64'(ex_wb_en_o), 64'(r[20]));
    check_value("ex_mem_r_en_o", 64'(ex_mem_r_en_o), 64'(r[16]));
    check_value("ex_mem_w_en_o", 64'(ex_mem_w_en_o), 64'(r[12]));
    check_value("ex_mem_mask_o", 64'(ex_mem_mask_o), 64'(r[11:4]));
    check_value("ex_mem_signed_o", 64'(ex_mem_signed_o), 64'(r[0]));
    check_value("ex_rs1_data_o", ex_rs1_data_o, field(v, F_OP1));
    check_value("ex_rs2_data_o", ex_rs2_data_o, field(v, F_OP2));
    check_value("ex_store_data_o", ex_store_data_o, field(v, F_ST));
    // the latch carries the pc of the instruction it holds
    check_value("ex_pc_o", ex_pc_o, field(v, F_PC));
  endtask

  initial begin
    int v;
    int unsigned target;
    drive_nop();
    $readmemh("tb/decode_stim.txt", stim);
    wait_reset_release();
    check_value("ex_wb_en_o", 64'(ex_wb_en_o), 64'd0);
    check_value("ex_mem_r_en_o", 64'(ex_mem_r_en_o), 64'd0);
    check_value("ex_mem_w_en_o", 64'(ex_mem_w_en_o), 64'd0);
    for (v = 0; v < NUM_VEC; v++) begin
      @(posedge clk_i);
      target = cycle + 1;
      apply_vector(v);
      wait_settle(target, $sformatf("vector %0d", v));
      check_comb(v);
      if (v > 0) check_reg(v - 1);
    end
    // one more edge to flush the last vector through the latch
    @(posedge clk_i);
    target = cycle + 1;
    drive_nop();
    wait_settle(target, "the final flush");
    check_reg(NUM_VEC - 1);
    $display("Regression passed");
    $finish;
  end

endmodule

//--- tb/decode_stim.txt
// pc inst ctl{pred,rs1_sel,rs1_ld,rs2_sel,rs2_ld} rs1 rs2 ex mem wb load comb redir_pc
// comb{rs1_addr,rs2_addr,rs1_en,rs2_en,redir} reg{op,sel,wb,wb_en,mr,mw,mask,sgn} op1 op2 store
1000 002081b3 00000 5 7 e0 d0 b0 a0 0102110 0 06403100001 5 7 0
1004 407302b3 02000 20 8 e0 d0 b0 a0 0607110 0 07405100001 b0 8 0
1008 002081b3 01000 5 7 e0 d0 b0 a0 0102110 0 06403100001 e0 7 0
100c 002081b3 03020 5 7 e0 d0 b0 a0 0102110 0 06403100001 d0 b0 0
1010 002081b3 03111 5 7 e0 d0 b0 a0 0102110 0 06403100001 a0 a0 0
1014 ffb58513 00000 64 7 e0 d0 b0 a0 0b00100 0 0640a100001 64 fffffffffffffffb 0
1018 0036a613 00000 9 7 e0 d0 b0 a0 0d00100 0 0930c100001 9 3 0
101c 4037d71b 00000 123 7 e0 d0 b0 a0 0f00100 0 0f20e100001 123 403 0
1020 12345a37 00000 5 7 e0 d0 b0 a0 0000000 0 01114100001 0 12345000 0
1024 fffffa97 00000 5 7 e0 d0 b0 a0 0000000 0 06415100001 1024 fffffffffffff000 0
1028 0104b403 00000 200 7 e0 d0 b0 a0 0900100 0 06408110ff1 200 10 0
102c fff4c403 00000 200 7 e0 d0 b0 a0 0900100 0 06408110010 200 ffffffffffffffff 0
1030 00249403 00000 200 7 e0 d0 b0 a0 0900100 0 06408110031 200 2 0
1034 0044e403 00000 200 7 e0 d0 b0 a0 0900100 0 064081100f0 200 4 0
1038 00a582a3 00000 300 8877665544332211 e0 d0 b0 a0 0b0a110 0 06400001011 300 5 11
103c fea59f23 00000 300 8877665544332211 e0 d0 b0 a0 0b0a110 0 06400001031 300 fffffffffffffffe 2211
1040 00a5a423 00000 300 8877665544332211 e0 d0 b0 a0 0b0a110 0 064000010f1 300 8 44332211
1044 00a5b823 00000 300 8877665544332211 e0 d0 b0 a0 0b0a110 0 06400001ff1 300 10 8877665544332211
1048 00208863 00000 5 5 e0 d0 b0 a0 0102111 1058 00000000001 5 5 0
104c 00209863 10000 5 5 e0 d0 b0 a0 0102111 1050 00000000001 5 5 0
1050 fe20cce3 10000 ffffffffffffffff 1 e0 d0 b0 a0 0102110 0 00000000001 ffffffffffffffff 1 0
1054 0020d863 00000 ffffffffffffffff 1 e0 d0 b0 a0 0102110 0 00000000001 ffffffffffffffff 1 0
1058 fe20ece3 00000 1 ffffffffffffffff e0 d0 b0 a0 0102111 1050 00000000001 1 ffffffffffffffff 0
105c 0020f863 10000 1 ffffffffffffffff e0 d0 b0 a0 0102111 1060 00000000001 1 ffffffffffffffff 0
1060 002081b3 10000 5 7 e0 d0 b0 a0 0102111 1064 06403100001 5 7 0
1064 020000ef 00000 5 7 e0 d0 b0 a0 0000000 0 06401100001 1064 4 0
1068 00c302e7 00000 2001 7 e0 d0 b0 a0 0600101 200c 06405100001 1068 4 0

//--- tb.f
hw/rv64_isa_pkg.sv
hw/exec_ctrl_pkg.sv
hw/inst_decoder.sv
hw/imm_gen.sv
hw/operand_forward.sv
hw/branch_resolve.sv
hw/ex_operand_latch.sv
hw/decode_stage.sv
tb/tb_decode_stage.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_decode_stage
FILELIST  = tb.f

SOURCES   = $(wildcard hw/*.sv) $(wildcard tb/*.sv)
BIN       = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
